// File: files.f
+incdir+source
source/mipsIsaPkg.sv
source/hazardPkg.sv
source/useDecoder.sv
source/producerDecoder.sv
source/hazardUnit.sv
source/mduTimer.sv
source/hazardTop.sv
testbench/hazard_properties.sv
testbench/hazardTb.sv

// File: run.sh
#!/bin/sh
# Build and run the hazard-control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module hazardTb

# Keep running after assertion errors so the summary is printed
out=$(./obj_dir/VhazardTb +verilator+error+limit+100000)
echo "$out"

echo "$out" | grep -qx "TESTS PASSED"

// File: testbench/hazardTb.sv
`timescale 1ns/1ps

module hazardTb;
    import mipsIsaPkg::*;

    logic  clk;
    logic  arstN;
    instrT instrD;
    logic  pcWrite;
    logic  mduBusy;
    instrT instrE;
    instrT instrM;

    int testsRun = 0;
    int testsFailed = 0;
    int errBefore;

    hazardTop u_dut (
        .clk     (clk),
        .arstN   (arstN),
        .instrD  (instrD),
        .pcWrite (pcWrite),
        .mduBusy (mduBusy),
        .instrE  (instrE),
        .instrM  (instrM)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic instrT rtype(functT fn, logic [4:0] rs, logic [4:0] rt, logic [4:0] rd);
        return '{op: opSpecial, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: fn};
    endfunction

    function automatic instrT itype(opcodeT op, logic [4:0] rs, logic [4:0] rt);
        return '{op: op, rs: rs, rt: rt, rd: 5'd0, shamt: 5'd0, funct: fnAdd};
    endfunction

    function automatic instrT cop0Move(logic [4:0] rt, logic [4:0] rd);
        return '{op: opCop0, rs: 5'b00100, rt: rt, rd: rd, shamt: 5'd0, funct: functT'(6'd0)};
    endfunction

    function automatic instrT eretInstr();
        return '{op: opCop0, rs: 5'b10000, rt: 5'd0, rd: 5'd0, shamt: 5'd0,
                 funct: functT'(6'b011000)};
    endfunction

    function automatic logic [4:0] anyReg();
        return 5'($urandom % 32);
    endfunction

    function automatic instrT randomInstr();
        case ($urandom % 10)
            0: return itype(opLw, anyReg(), anyReg());
            1: return itype(opSw, anyReg(), anyReg());
            2: return itype(opBeq, anyReg(), anyReg());
            3: return itype(opAddi, anyReg(), anyReg());
            4: return rtype(fnMult, anyReg(), anyReg(), 5'd0);
            5: return rtype(fnDiv, anyReg(), anyReg(), 5'd0);
            6: return rtype(fnMflo, 5'd0, 5'd0, anyReg());
            7: return rtype(fnJr, anyReg(), 5'd0, 5'd0);
            8: return itype(opJal, 5'd0, 5'd0);
            default: return rtype(fnSub, anyReg(), anyReg(), anyReg());
        endcase
    endfunction

    task automatic abortRun(input string why);
        $display("Timeout: %s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input instrT i);
        int waited;
        bit taken;
        waited = 0;
        taken = 1'b0;
        instrD = i;
        while (!taken) begin
            #1;
            taken = pcWrite;
            @(negedge clk);
            waited++;
            if (waited > 40) abortRun("instruction held in decode for 40 cycles");
        end
        instrD = '0;
    endtask

    task automatic drain();
        repeat (3) issue('0);
    endtask

    task automatic waitMduIdle();
        int waited;
        waited = 0;
        while (mduBusy) begin
            @(negedge clk);
            waited++;
            if (waited > 40) abortRun("mduBusy never dropped");
        end
    endtask

    task automatic startTest();
        errBefore = u_dut.uProps.errCount;
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = u_dut.uProps.errCount - errBefore;
        testsRun++;
        if (errs != 0) testsFailed++;
        $display("test %-12s %s (%0d assertion failures)", name, errs == 0 ? "ok" : "bad", errs);
    endtask

    initial begin
        instrT rnd;
        void'($urandom(32'hfa0413a1));
        arstN = 1'b0;
        instrD = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        startTest();
        issue(itype(opLw, 5'd1, 5'd2));
        issue(rtype(fnAdd, 5'd2, 5'd4, 5'd3));
        drain();
        issue(itype(opLw, 5'd1, 5'd5));
        issue(itype(opAddi, 5'd9, 5'd6));
        issue(rtype(fnAdd, 5'd5, 5'd5, 5'd7));
        drain();
        endTest("load-use");

        startTest();
        issue(rtype(fnAdd, 5'd1, 5'd2, 5'd8));
        issue(itype(opSw, 5'd9, 5'd8));
        drain();
        issue(rtype(fnAdd, 5'd1, 5'd2, 5'd10));
        issue(itype(opBeq, 5'd10, 5'd0));
        drain();
        endTest("store-data");

        startTest();
        repeat (20) begin
            issue(rtype(fnOr, anyReg(), anyReg(), 5'd0));
            issue(rtype(fnAdd, 5'd0, 5'd0, anyReg()));
            issue(itype(opSb, anyReg(), anyReg()));
            rnd = randomInstr();
            issue(rnd);
        end
        drain();
        waitMduIdle();
        endTest("reg-zero");

        ////////////////////////////////////////
        // MDU busy and collisions
        ////////////////////////////////////////
        startTest();
        issue(rtype(fnMult, 5'd1, 5'd2, 5'd0));
        issue(rtype(fnMfhi, 5'd0, 5'd0, 5'd3));
        drain();
        issue(rtype(fnDiv, 5'd1, 5'd2, 5'd0));
        issue(rtype(fnMflo, 5'd0, 5'd0, 5'd4));
        drain();
        issue(rtype(fnMult, 5'd1, 5'd2, 5'd0));
        // Meets the start, then the busy timer
        issue(rtype(fnMultu, 5'd3, 5'd4, 5'd0));
        issue(rtype(fnDiv, 5'd5, 5'd6, 5'd0));
        waitMduIdle();
        drain();
        endTest("mdu");

        startTest();
        issue(cop0Move(5'd4, 5'd14));
        issue(eretInstr());
        drain();
        issue(cop0Move(5'd4, 5'd12));
        issue(eretInstr());
        drain();
        endTest("eret");

        startTest();
        repeat (60) begin
            rnd = randomInstr();
            issue(rnd);
        end
        drain();
        waitMduIdle();
        endTest("bubbles");

        $display("tests run %0d, tests failing %0d, assertion failures %0d",
                 testsRun, testsFailed, u_dut.uProps.errCount);
        if (testsFailed == 0 && u_dut.uProps.errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/hazard_properties.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module hazardProperties
    import mipsIsaPkg::*;
(
    input logic  clk,
    input logic  arstN,
    input instrT instrD,
    input instrT instrE,
    input instrT instrM,
    input logic  pcWrite,
    input logic  mduBusy
);

    int unsigned errCount = 0;
    int          remaining;
    logic [6:0]  rsD, rtD, newE, newM;
    logic        mdE, mduOn, dropD, expStall;

    // {register, Tuse} read by a decode-stage instruction
    function automatic logic [6:0] useOf(instrT i, bit pickRt);
        logic [6:0] rsU, rtU;
        rsU = '0;
        rtU = '0;
        case (i.op)
            opSpecial: begin
                if (i.funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
                                    fnMult, fnMultu, fnDiv, fnDivu}) begin
                    rsU = {i.rs, 2'd1};
                    rtU = {i.rt, 2'd1};
                end else if (i.funct inside {fnMthi, fnMtlo}) rsU = {i.rs, 2'd1};
                else if (i.funct == fnJr) rsU = {i.rs, 2'd0};
            end
            opOri, opAddi, opAndi, opLw, opLb, opLh: rsU = {i.rs, 2'd1};
            opSw, opSb, opSh: begin
                rsU = {i.rs, 2'd1};
                rtU = {i.rt, 2'd2};
            end
            opBeq, opBne: begin
                rsU = {i.rs, 2'd0};
                rtU = {i.rt, 2'd0};
            end
            opCop0: if (i.rs == 5'b00100) rtU = {i.rt, 2'd2};
            default: rsU = '0;
        endcase
        return pickRt ? rtU : rsU;
    endfunction

    // {destination, Tnew} seen from execute
    function automatic logic [6:0] newOf(instrT i);
        case (i.op)
            opSpecial: begin
                if (i.funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu, fnMfhi, fnMflo})
                    return {i.rd, 2'd1};
                return '0;
            end
            opOri, opAddi, opAndi, opLui: return {i.rt, 2'd1};
            opLw, opLb, opLh: return {i.rt, 2'd2};
            opJal: return {5'd31, 2'd0};
            default: return '0;
        endcase
    endfunction

    function automatic logic blocks(logic [6:0] u, logic [6:0] p);
        return (u[6:2] != 5'd0) && (u[6:2] == p[6:2]) && (u[1:0] < p[1:0]);
    endfunction

    function automatic logic mulDivOp(instrT i);
        return (i.op == opSpecial) && (i.funct inside {fnMult, fnMultu, fnDiv, fnDivu});
    endfunction

    function automatic logic mtc0Epc(instrT i);
        return (i.op == opCop0) && (i.rs == 5'b00100) && (i.rd == `REG_W'(`EPC_REG));
    endfunction

    always_comb begin
        rsD   = useOf(instrD, 1'b0);
        rtD   = useOf(instrD, 1'b1);
        newE  = newOf(instrE);
        newM  = newOf(instrM);
        // One stage older, so one cycle closer
        newM[1:0] = (newM[1:0] == 2'd0) ? 2'd0 : newM[1:0] - 2'd1;
        mdE   = mulDivOp(instrE);
        mduOn = mduBusy | mdE;
        expStall = blocks(rsD, newE) | blocks(rsD, newM) | blocks(rtD, newE) | blocks(rtD, newM)
            | (mduOn && instrD.op == opSpecial
               && instrD.funct inside {fnMfhi, fnMflo, fnMthi, fnMtlo})
            | (instrD.op == opCop0 && instrD.rs == 5'b10000 && instrD.funct == 6'b011000
               && (mtc0Epc(instrE) || mtc0Epc(instrM)));
        dropD = mduOn & mulDivOp(instrD) & ~expStall;
    end

    // Reference busy counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) remaining <= 0;
        else if (mdE) remaining <= (instrE.funct inside {fnMult, fnMultu})
            ? `MULT_CYCLES : `DIV_CYCLES;
        else if (remaining != 0) remaining <= remaining - 1;
    end

    stallRule: assert property (@(posedge clk) disable iff (!arstN) pcWrite == !expStall)
        else begin
            $error("ERR %0t pcWrite expected %b got %b", $time, !expStall, pcWrite);
            errCount++;
        end

    busyLength: assert property (@(posedge clk) disable iff (!arstN) mduBusy == (remaining != 0))
        else begin
            $error("ERR %0t mduBusy expected %b got %b", $time, remaining != 0, mduBusy);
            errCount++;
        end

    bubbleIn: assert property (@(posedge clk) disable iff (!arstN)
        $past(!pcWrite || dropD) |-> instrE == '0)
        else begin
            $error("ERR %0t instrE expected %h got %h", $time, 32'h0, instrE);
            errCount++;
        end

    advance: assert property (@(posedge clk) disable iff (!arstN)
        $past(pcWrite && !dropD) |-> instrE == $past(instrD))
        else begin
            $error("ERR %0t instrE expected %h got %h", $time, $past(instrD), instrE);
            errCount++;
        end

    memAdvance: assert property (@(posedge clk) disable iff (!arstN) instrM == $past(instrE))
        else begin
            $error("ERR %0t instrM expected %h got %h", $time, $past(instrE), instrM);
            errCount++;
        end

    afterReset: assert property (@(posedge clk) $past(!arstN) && arstN |-> pcWrite && !mduBusy)
        else begin
            $error("pcWrite low or mduBusy high right after reset");
            errCount++;
        end

endmodule

bind hazardTop hazardProperties uProps (.*);

// File: source/hazardTop.sv
`timescale 1ns/1ps

module hazardTop
    import mipsIsaPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  instrT instrD,
    output logic  pcWrite,
    output logic  mduBusy,
    output instrT instrE,
    output instrT instrM
);

    logic stall;
    logic mduClr;
    logic mduStart;

    hazardUnit uHazardUnit (
        .clk      (clk),
        .arstN    (arstN),
        .instrD   (instrD),
        .instrE   (instrE),
        .instrM   (instrM),
        .mduBusy  (mduBusy),
        .mduStart (mduStart),
        .stall    (stall),
        .mduClr   (mduClr)
    );

    mduTimer uMduTimer (
        .clk      (clk),
        .arstN    (arstN),
        .instrE   (instrE),
        .mduStart (mduStart),
        .mduBusy  (mduBusy)
    );

    assign pcWrite = ~stall;

    ////////////////////////////////////////
    // D/E and E/M instruction registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrE <= '0;
            instrM <= '0;
        end else begin
            // Bubble on stall, drop a colliding mult/div
            if (stall || mduClr) begin
                instrE <= '0;
            end else begin
                instrE <= instrD;
            end
            instrM <= instrE;
        end
    end

endmodule

// File: source/mduTimer.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mduTimer
    import mipsIsaPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  instrT instrE,
    output logic  mduStart,
    output logic  mduBusy
);

    typedef enum logic [1:0] {
        IDLE,
        MULTIPLYING,
        DIVIDING
    } mduStateT;

    localparam int cntW = $clog2(`DIV_CYCLES + 1);

    mduStateT        state;
    logic [cntW-1:0] count;

    // Start is the mult/div sitting in execute
    assign mduStart = isMulDiv(instrE);
    assign mduBusy  = (state != IDLE);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
            count <= '0;
        end else if (mduStart) begin
            if (instrE.funct inside {fnMult, fnMultu}) begin
                state <= MULTIPLYING;
                count <= cntW'(`MULT_CYCLES);
            end else begin
                state <= DIVIDING;
                count <= cntW'(`DIV_CYCLES);
            end
        end else if (state != IDLE) begin
            // Last busy cycle when count is one
            if (count == cntW'(1)) begin
                state <= IDLE;
            end
            count <= count - 1'b1;
        end
    end

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module hazardUnit
    import mipsIsaPkg::*, hazardPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  instrT instrD,
    input  instrT instrE,
    input  instrT instrM,
    input  logic  mduBusy,
    input  logic  mduStart,
    output logic  stall,
    output logic  mduClr
);

    useT  rsUseD;
    useT  rtUseD;
    newT  prodE;
    newT  prodM;
    logic tuseStall;
    logic hiLoStall;
    logic eretStall;
    logic mduActive;

    // Register zero is never a true dependency
    function automatic logic waitsOn(useT src, newT prod);
        return (src.num != '0) && (src.num == prod.dst) && (src.tUse < prod.tNew);
    endfunction

    function automatic logic isHiLoAccess(instrT instr);
        return (instr.op == opSpecial) &&
               (instr.funct inside {fnMfhi, fnMflo, fnMthi, fnMtlo});
    endfunction

    function automatic logic isEret(instrT instr);
        return (instr.op == opCop0) && (instr.rs == cop0Co) && (instr.funct == eretFunct);
    endfunction

    function automatic logic isMtc0Epc(instrT instr);
        return (instr.op == opCop0) && (instr.rs == cop0Mt) &&
               (instr.rd == `REG_W'(`EPC_REG));
    endfunction

    useDecoder uUseDecoder (
        .instr (instrD),
        .rsUse (rsUseD),
        .rtUse (rtUseD)
    );

    producerDecoder uProducerDecoder (
        .instr (instrE),
        .prod  (prodE)
    );

    ////////////////////////////////////////
    // Producer ageing into memory stage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prodM <= '0;
        end else begin
            prodM.dst  <= prodE.dst;
            prodM.tNew <= (prodE.tNew == 2'd0) ? 2'd0 : prodE.tNew - 2'd1;
        end
    end

    ////////////////////////////////////////
    // Stall and MDU clear
    ////////////////////////////////////////

    assign tuseStall = waitsOn(rsUseD, prodE) | waitsOn(rsUseD, prodM) |
                       waitsOn(rtUseD, prodE) | waitsOn(rtUseD, prodM);

    assign mduActive = mduBusy | mduStart;
    assign hiLoStall = mduActive & isHiLoAccess(instrD);

    // EPC must be written before eret reads it
    assign eretStall = isEret(instrD) & (isMtc0Epc(instrE) | isMtc0Epc(instrM));

    assign stall  = tuseStall | hiLoStall | eretStall;
    assign mduClr = mduActive & isMulDiv(instrD) & ~stall;

endmodule

// File: source/producerDecoder.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module producerDecoder
    import mipsIsaPkg::*, hazardPkg::*;
(
    input  instrT instr,
    output newT   prod
);

    // Tnew as seen from the execute stage
    always_comb begin
        prod = '0;
        case (instr.op)
            opSpecial: begin
                case (instr.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
                    fnMfhi, fnMflo: begin
                        prod = '{dst: instr.rd, tNew: 2'd1};
                    end
                    // jr, mult/div, mthi/mtlo write no GPR
                    default: begin
                        prod = '0;
                    end
                endcase
            end

            opOri, opAddi, opAndi, opLui: begin
                prod = '{dst: instr.rt, tNew: 2'd1};
            end

            // Data arrives after the memory stage
            opLw, opLb, opLh: begin
                prod = '{dst: instr.rt, tNew: 2'd2};
            end

            // Link address is known already in E
            opJal: begin
                prod = '{dst: `REG_W'(31), tNew: 2'd0};
            end

            // Stores, branches, j and COP0
            default: begin
                prod = '0;
            end
        endcase
    end

endmodule

// File: source/useDecoder.sv
`timescale 1ns/1ps

module useDecoder
    import mipsIsaPkg::*, hazardPkg::*;
(
    input  instrT instr,
    output useT   rsUse,
    output useT   rtUse
);

    always_comb begin
        rsUse = '0;
        rtUse = '0;
        case (instr.op)
            opSpecial: begin
                case (instr.funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt, fnSltu,
                    fnMult, fnMultu, fnDiv, fnDivu: begin
                        rsUse = '{num: instr.rs, tUse: 2'd1};
                        rtUse = '{num: instr.rt, tUse: 2'd1};
                    end
                    fnMthi, fnMtlo: begin
                        rsUse = '{num: instr.rs, tUse: 2'd1};
                    end
                    // Jump target resolved in decode
                    fnJr: begin
                        rsUse = '{num: instr.rs, tUse: 2'd0};
                    end
                    // mfhi and mflo read no GPR
                    default: begin
                        rsUse = '0;
                    end
                endcase
            end

            // Immediate ALU and loads
            opOri, opAddi, opAndi, opLw, opLb, opLh: begin
                rsUse = '{num: instr.rs, tUse: 2'd1};
            end

            // Store data is needed one stage later than the address
            opSw, opSb, opSh: begin
                rsUse = '{num: instr.rs, tUse: 2'd1};
                rtUse = '{num: instr.rt, tUse: 2'd2};
            end

            // Compare in decode
            opBeq, opBne: begin
                rsUse = '{num: instr.rs, tUse: 2'd0};
                rtUse = '{num: instr.rt, tUse: 2'd0};
            end

            opCop0: begin
                if (instr.rs == cop0Mt) begin
                    rtUse = '{num: instr.rt, tUse: 2'd2};
                end
            end

            // lui, j, jal
            default: begin
                rsUse = '0;
            end
        endcase
    end

endmodule

// File: source/hazardPkg.sv
package hazardPkg;

`include "mips_params.svh"

    ////////////////////////////////////////
    // Consumer side, decode stage
    ////////////////////////////////////////

    // num is zero when the operand is not read
    typedef struct packed {
        logic [`REG_W-1:0] num;
        logic [1:0]        tUse;
    } useT;

    ////////////////////////////////////////
    // Producer side, execute and memory
    ////////////////////////////////////////

    // dst is zero for non-writers, so no separate write enable
    typedef struct packed {
        logic [`REG_W-1:0] dst;
        logic [1:0]        tNew;
    } newT;

endpackage

// File: source/mipsIsaPkg.sv
package mipsIsaPkg;

`include "mips_params.svh"

    // Primary opcode field
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opCop0    = 6'b010000,
        opOri     = 6'b001101,
        opAddi    = 6'b001000,
        opAndi    = 6'b001100,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opSw      = 6'b101011,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opJ       = 6'b000010,
        opJal     = 6'b000011
    } opcodeT;

    // Function field of SPECIAL
    typedef enum logic [5:0] {
        fnAdd   = 6'b100000,
        fnSub   = 6'b100010,
        fnAnd   = 6'b100100,
        fnOr    = 6'b100101,
        fnSlt   = 6'b101010,
        fnSltu  = 6'b101011,
        fnMult  = 6'b011000,
        fnMultu = 6'b011001,
        fnDiv   = 6'b011010,
        fnDivu  = 6'b011011,
        fnMfhi  = 6'b010000,
        fnMflo  = 6'b010010,
        fnMthi  = 6'b010001,
        fnMtlo  = 6'b010011,
        fnJr    = 6'b001000
    } functT;

    // COP0 format, carried in the rs slot
    typedef enum logic [4:0] {
        cop0Mf = 5'b00000,
        cop0Mt = 5'b00100,
        cop0Co = 5'b10000
    } cop0FmtT;

    // eret under cop0Co
    localparam logic [5:0] eretFunct = 6'b011000;

    typedef struct packed {
        opcodeT            op;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
        logic [4:0]        shamt;
        functT             funct;
    } instrT;

    // Anything that starts the MDU
    function automatic logic isMulDiv(instrT instr);
        return (instr.op == opSpecial) &&
               (instr.funct inside {fnMult, fnMultu, fnDiv, fnDivu});
    endfunction

endpackage

// File: source/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

////////////////////////////////////////
// Register file addressing
////////////////////////////////////////

// GPR and CP0 register number width
`define REG_W 5

////////////////////////////////////////
// Multiply/divide unit
////////////////////////////////////////

// Busy cycles after a start
`define MULT_CYCLES 5
`define DIV_CYCLES 10

// CP0 exception PC
`define EPC_REG 14

`endif
